// File: source/rmii_pkg.sv
`default_nettype none

package rmii_pkg;

  // Bus widths on both sides of the bridge
  localparam int DIBIT_W  = 2;   // RMII data
  localparam int NIBBLE_W = 4;   // MII data

  // RMII_CLK cycles per dibit at 10 Mb/s
  localparam int SLOW_DIV  = 10;
  localparam int DIV_CNT_W = $clog2(SLOW_DIV);

  // Line codes seen on rxd during frame start
  localparam logic [DIBIT_W-1:0] PREAMBLE_DIBIT = 2'b01;
  localparam logic [DIBIT_W-1:0] SFD_DIBIT      = 2'b11;   // Last dibit of the SFD

  // Same codes as MII nibbles
  localparam logic [NIBBLE_W-1:0] PREAMBLE_NIBBLE = 4'h5;
  localparam logic [NIBBLE_W-1:0] SFD_NIBBLE      = 4'hD;

  typedef logic [DIBIT_W-1:0]  dibit_t;
  typedef logic [NIBBLE_W-1:0] nibble_t;

  // Line rate select, follows the speed pin
  typedef enum logic
  {
    SPEED_10  = 1'b0,
    SPEED_100 = 1'b1
  } speed_t;

  // Receive framer states
  typedef enum logic [1:0]
  {
    RX_IDLE          = 2'd0,
    RX_PREAMBLE      = 2'd1,
    RX_DATA          = 2'd2,
    RX_FALSE_CARRIER = 2'd3   // Bad start code, wait for crs_dv low
  } rx_state_t;

endpackage

`default_nettype wire

// File: source/mii_clock_gen.sv
`default_nettype none

module mii_clock_gen
(
  input  wire              RMII_CLK,
  input  wire              RMRESETN,
  input  wire              speed,
  output rmii_pkg::speed_t speed_sync,
  output logic             dibit_stb,
  output logic             mii_rise,
  output logic             mii_fall,
  output logic             mii_clk
);

  import rmii_pkg::*;

  speed_t               speed_meta;
  logic [DIV_CNT_W-1:0] rate_cnt;

  // Speed pin is asynchronous to RMII_CLK
  always_ff @(posedge RMII_CLK or negedge RMRESETN)
  begin
    if (!RMRESETN)
    begin
      speed_meta <= SPEED_10;
      speed_sync <= SPEED_10;
    end
    else
    begin
      speed_meta <= speed_t'(speed);
      speed_sync <= speed_meta;
    end
  end

  // Divide by SLOW_DIV at 10 Mb/s, counter parked at 100 Mb/s
  always_ff @(posedge RMII_CLK or negedge RMRESETN)
  begin
    if (!RMRESETN)
      rate_cnt <= '0;
    else if (speed_sync == SPEED_100 || dibit_stb)
      rate_cnt <= '0;
    else
      rate_cnt <= rate_cnt + 1'b1;
  end

  assign dibit_stb = (speed_sync == SPEED_100) ||
                     (rate_cnt == DIV_CNT_W'(SLOW_DIV - 1));

  // Registered MII clock, one half period per dibit period
  always_ff @(posedge RMII_CLK or negedge RMRESETN)
  begin
    if (!RMRESETN)
      mii_clk <= 1'b0;
    else if (dibit_stb)
      mii_clk <= !mii_clk;
  end

  assign mii_rise = dibit_stb && !mii_clk;   // Edge ending this cycle raises mii_clk
  assign mii_fall = dibit_stb && mii_clk;

  // At full rate the MII clock runs at half of RMII_CLK
  a_fast_toggle : assert property (@(posedge RMII_CLK) disable iff (!RMRESETN)
    (speed_sync == SPEED_100) |-> dibit_stb ##1 (mii_clk != $past(mii_clk)));

endmodule

`default_nettype wire

// File: source/rmii_tx_serializer.sv
`default_nettype none

module rmii_tx_serializer
(
  input  wire               RMII_CLK,
  input  wire               RMRESETN,
  input  wire               dibit_stb,
  input  wire               mii_rise,
  input  wire               mii_tx_en,
  input  wire rmii_pkg::nibble_t mii_txd,
  output logic              tx_en,
  output rmii_pkg::dibit_t  txd
);

  import rmii_pkg::*;

  dibit_t hi_dibit;   // Upper half of the nibble, sent second

  // Nibble taken on the rising MII edge, low dibit goes out at once
  always_ff @(posedge RMII_CLK or negedge RMRESETN)
  begin
    if (!RMRESETN)
    begin
      tx_en <= 1'b0;
      txd   <= '0;
    end
    else if (mii_rise)
    begin
      tx_en <= mii_tx_en;
      if (mii_tx_en)
        txd <= mii_txd[DIBIT_W-1:0];
      else
        txd <= '0;
    end
    else if (dibit_stb)
    begin
      // Falling MII edge, second half of the same nibble
      if (tx_en)
        txd <= hi_dibit;
      else
        txd <= '0;
    end
  end

  always_ff @(posedge RMII_CLK)
  begin
    if (mii_rise)
      hi_dibit <= mii_txd[NIBBLE_W-1:DIBIT_W];
  end

  // Line stays quiet between frames, in both halves of the nibble
  a_txd_idle : assert property (@(posedge RMII_CLK) disable iff (!RMRESETN)
    !tx_en |-> (txd == '0));

endmodule

`default_nettype wire

// File: source/rmii_rx_framer.sv
`default_nettype none

module rmii_rx_framer
(
  input  wire               RMII_CLK,
  input  wire               RMRESETN,
  input  wire               dibit_stb,
  input  wire               crs_dv,
  input  wire               rx_er,
  input  wire rmii_pkg::dibit_t rxd,
  output logic              carrier,
  output logic              nib_wr,
  output logic              nib_err,
  output rmii_pkg::nibble_t nib_data
);

  import rmii_pkg::*;

  rx_state_t state_q;
  rx_state_t state_d;
  logic      half_q;      // Set when last_dibit is the low half of a nibble
  logic      half_d;
  dibit_t    last_dibit;
  logic      last_err;

  // Next state and nibble write, evaluated once per dibit
  always_comb
  begin
    state_d = state_q;
    half_d  = half_q;
    nib_wr  = 1'b0;
    if (dibit_stb)
    begin
      if (!crs_dv)
      begin
        // End of frame, a dangling half nibble is dropped
        state_d = RX_IDLE;
        half_d  = 1'b0;
      end
      else
      begin
        case (state_q)
          RX_IDLE:
          begin
            if (rxd == PREAMBLE_DIBIT)
            begin
              state_d = RX_PREAMBLE;
              half_d  = 1'b1;   // First preamble dibit opens a nibble
            end
            else
            begin
              state_d = RX_FALSE_CARRIER;
            end
          end
          RX_PREAMBLE:
          begin
            if (rxd == SFD_DIBIT)
            begin
              // Realign on the SFD, previous preamble dibit is the low half
              state_d = RX_DATA;
              half_d  = 1'b0;
              nib_wr  = 1'b1;
            end
            else
            begin
              nib_wr = half_q;
              half_d = !half_q;
            end
          end
          RX_DATA:
          begin
            nib_wr = half_q;
            half_d = !half_q;
          end
          default:
          begin
            state_d = state_q;   // False carrier, nothing written
          end
        endcase
      end
    end
  end

  assign nib_data = {rxd, last_dibit};   // Low dibit arrived first
  assign nib_err  = rx_er || last_err;

  always_ff @(posedge RMII_CLK or negedge RMRESETN)
  begin
    if (!RMRESETN)
    begin
      state_q <= RX_IDLE;
      half_q  <= 1'b0;
      carrier <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      half_q  <= half_d;
      if (dibit_stb)
        carrier <= crs_dv;
    end
  end

  // Previous dibit and its error flag
  always_ff @(posedge RMII_CLK)
  begin
    if (dibit_stb)
    begin
      last_dibit <= rxd;
      last_err   <= rx_er;
    end
  end

  // Writes come only in frame states, which carrier must reflect
  a_wr_on_stb : assert property (@(posedge RMII_CLK) disable iff (!RMRESETN)
    nib_wr |-> (dibit_stb && carrier));

endmodule

`default_nettype wire

// File: source/rx_nibble_buffer.sv
`default_nettype none

module rx_nibble_buffer
(
  input  wire               RMII_CLK,
  input  wire               RMRESETN,
  input  wire               mii_fall,
  input  wire               nib_wr,
  input  wire               nib_err,
  input  wire               carrier,
  input  wire rmii_pkg::nibble_t nib_data,
  output logic              rx_dv,
  output logic              mii_rx_er,
  output logic              crs,
  output rmii_pkg::nibble_t mii_rxd
);

  import rmii_pkg::*;

  nibble_t    mem_data [2];
  logic       mem_err [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;   // 0 to 2 entries
  logic       pop;

  assign pop = mii_fall && (count != 2'd0);

  always_ff @(posedge RMII_CLK)
  begin
    if (nib_wr)
    begin
      mem_data[wr_ptr] <= nib_data;
      mem_err[wr_ptr]  <= nib_err;
    end
  end

  always_ff @(posedge RMII_CLK or negedge RMRESETN)
  begin
    if (!RMRESETN)
    begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end
    else
    begin
      wr_ptr <= wr_ptr ^ nib_wr;
      rd_ptr <= rd_ptr ^ pop;
      count  <= count + 2'(nib_wr) - 2'(pop);
    end
  end

  // MII outputs change on the falling MII edge, MAC samples on the rise
  always_ff @(posedge RMII_CLK or negedge RMRESETN)
  begin
    if (!RMRESETN)
    begin
      rx_dv     <= 1'b0;
      mii_rx_er <= 1'b0;
      mii_rxd   <= '0;
      crs       <= 1'b0;
    end
    else if (mii_fall)
    begin
      crs       <= carrier;
      rx_dv     <= pop;
      mii_rx_er <= pop && mem_err[rd_ptr];
      mii_rxd   <= pop ? mem_data[rd_ptr] : '0;   // Underrun ends rx_dv
    end
  end

  // Framer and drain rate keep at most two nibbles in flight
  a_no_overflow : assert property (@(posedge RMII_CLK) disable iff (!RMRESETN)
    nib_wr |-> (count != 2'd2));

endmodule

`default_nettype wire

// File: source/rmii_mii_bridge.sv
`default_nettype none

module rmii_mii_bridge
(
  input  wire                    RMII_CLK,
  input  wire                    RMRESETN,
  input  wire                    speed,       // 1 selects 100 Mb/s
  input  wire                    crs_dv,
  input  wire                    rx_er,
  input  wire rmii_pkg::dibit_t  rxd,
  input  wire                    mii_tx_en,
  input  wire rmii_pkg::nibble_t mii_txd,
  output rmii_pkg::dibit_t       txd,
  output logic                   tx_en,
  output logic                   mii_clk,     // TX_CLK and RX_CLK toward the MAC
  output logic                   rx_dv,
  output logic                   mii_rx_er,
  output rmii_pkg::nibble_t      mii_rxd,
  output logic                   crs,
  output logic                   col
);

  import rmii_pkg::*;

  logic    dibit_stb;
  logic    mii_rise;
  logic    mii_fall;
  logic    carrier;
  logic    nib_wr;
  logic    nib_err;
  nibble_t nib_data;

  mii_clock_gen u_clk_gen
  (
    .RMII_CLK   (RMII_CLK),
    .RMRESETN   (RMRESETN),
    .speed      (speed),
    .speed_sync (),
    .dibit_stb  (dibit_stb),
    .mii_rise   (mii_rise),
    .mii_fall   (mii_fall),
    .mii_clk    (mii_clk)
  );

  rmii_tx_serializer u_tx
  (
    .RMII_CLK  (RMII_CLK),
    .RMRESETN  (RMRESETN),
    .dibit_stb (dibit_stb),
    .mii_rise  (mii_rise),
    .mii_tx_en (mii_tx_en),
    .mii_txd   (mii_txd),
    .tx_en     (tx_en),
    .txd       (txd)
  );

  rmii_rx_framer u_rx
  (
    .RMII_CLK  (RMII_CLK),
    .RMRESETN  (RMRESETN),
    .dibit_stb (dibit_stb),
    .crs_dv    (crs_dv),
    .rx_er     (rx_er),
    .rxd       (rxd),
    .carrier   (carrier),
    .nib_wr    (nib_wr),
    .nib_err   (nib_err),
    .nib_data  (nib_data)
  );

  rx_nibble_buffer u_buf
  (
    .RMII_CLK  (RMII_CLK),
    .RMRESETN  (RMRESETN),
    .mii_fall  (mii_fall),
    .nib_wr    (nib_wr),
    .nib_err   (nib_err),
    .carrier   (carrier),
    .nib_data  (nib_data),
    .rx_dv     (rx_dv),
    .mii_rx_er (mii_rx_er),
    .crs       (crs),
    .mii_rxd   (mii_rxd)
  );

  // Half duplex collision, MAC transmits while the line carries a frame
  assign col = mii_tx_en && crs;

endmodule

`default_nettype wire

// File: tests/tb_helpers.svh
`ifndef TB_HELPERS_SVH
`define TB_HELPERS_SVH

logic [31:0] lcg_state = 32'h8eaaae41;   // Fixed seed
int          check_count = 0;
int          error_count = 0;

nibble_t     tx_nibs [$];       // MAC nibbles of one transmit frame
dibit_t      data_dibits [$];   // Receive payload dibits, after the SFD
logic [3:0]  exp_vals [$];
logic        exp_errs [$];
logic [3:0]  got_vals [$];
logic        got_errs [$];

function automatic logic [31:0] next_random();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// Upper bits of the LCG carry the better randomness
function automatic int rand_range(input int lo, input int hi);
  logic [31:0] r;
  r = next_random();
  return lo + int'(r[31:8] % (hi - lo + 1));
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
  check_count++;
  if (expected !== actual)
  begin
    error_count++;
    $display("[FAIL] %s expected %h actual %h", name, expected, actual);
  end
endtask

// Each MAC nibble leaves as its low dibit, then its high dibit
function automatic void model_tx_dibits();
  exp_vals.delete();
  foreach (tx_nibs[i])
  begin
    exp_vals.push_back({2'b00, tx_nibs[i][1:0]});
    exp_vals.push_back({2'b00, tx_nibs[i][3:2]});
  end
endfunction

// floor(k/2) preamble nibbles, the SFD nibble, then payload pairs low dibit first
function automatic void model_rx_nibbles(input int k, input int err_idx);
  exp_vals.delete();
  exp_errs.delete();
  for (int i = 0; i < k / 2; i++)
  begin
    exp_vals.push_back(PREAMBLE_NIBBLE);
    exp_errs.push_back(1'b0);
  end
  exp_vals.push_back(SFD_NIBBLE);
  exp_errs.push_back(1'b0);
  for (int j = 0; j < data_dibits.size() / 2; j++)
  begin
    exp_vals.push_back({data_dibits[2 * j + 1], data_dibits[2 * j]});
    exp_errs.push_back(err_idx / 2 == j);
  end
endfunction

`endif

// File: tests/tb_rmii_mii.sv
`default_nettype none

module tb_rmii_mii;

  import rmii_pkg::*;

  localparam int TX_TIMEOUT   = 2000;   // RMII_CLK cycles per frame
  localparam int RX_TIMEOUT   = 2500;
  localparam int EDGE_TIMEOUT = 50;

  logic    RMII_CLK;
  logic    RMRESETN;
  logic    speed;
  logic    crs_dv;
  logic    rx_er;
  dibit_t  rxd;
  logic    mii_tx_en;
  nibble_t mii_txd;
  dibit_t  txd;
  logic    tx_en;
  logic    mii_clk;
  logic    rx_dv;
  logic    mii_rx_er;
  nibble_t mii_rxd;
  logic    crs;
  logic    col;
  int      test_count = 0;

  `include "tb_helpers.svh"

  rmii_mii_bridge dut0 (.*);

  initial
  begin
    RMII_CLK = 1'b0;
    forever #20 RMII_CLK = !RMII_CLK;
  end

  // All stimulus changes 2 units after the rising edge
  task automatic next_cycle();
    @(posedge RMII_CLK);
    #2;
  endtask

  task automatic report_timeout(input string what);
    error_count++;
    $display("Timeout while waiting for %s", what);
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_count++;
    $display("Test %0d %s finished with %0d errors", test_count, name,
             error_count - errs_before);
  endtask

  task automatic apply_reset(input logic fast);
    next_cycle();
    RMRESETN  = 1'b0;
    speed     = fast;
    crs_dv    = 1'b0;
    rx_er     = 1'b0;
    rxd       = '0;
    mii_tx_en = 1'b0;
    mii_txd   = '0;
    repeat (2) next_cycle();
    RMRESETN = 1'b1;
  endtask

  task automatic wait_mii_clk(input logic level);
    int n;
    n = 0;
    while (mii_clk == level && n < EDGE_TIMEOUT)
    begin
      next_cycle();
      n++;
    end
    while (mii_clk != level && n < EDGE_TIMEOUT)
    begin
      next_cycle();
      n++;
    end
    if (n >= EDGE_TIMEOUT)
      report_timeout("an edge of mii_clk");
  endtask

  task automatic measure_halves(input int expected);
    int n;
    wait_mii_clk(1'b1);
    n = 0;
    while (mii_clk && n < EDGE_TIMEOUT)
    begin
      next_cycle();
      n++;
    end
    check_value("mii_clk high cycles", expected, n);
    n = 0;
    while (!mii_clk && n < EDGE_TIMEOUT)
    begin
      next_cycle();
      n++;
    end
    check_value("mii_clk low cycles", expected, n);
  endtask

  task automatic compare_stream(input string name, input logic with_err);
    check_value({name, " count"}, exp_vals.size(), got_vals.size());
    for (int i = 0; i < exp_vals.size() && i < got_vals.size(); i++)
    begin
      check_value(name, exp_vals[i], got_vals[i]);
      if (with_err)
        check_value("mii_rx_er", exp_errs[i], got_errs[i]);
    end
  endtask

  // MAC drives a nibble per mii_clk rise and the RMII line is captured per dibit
  task automatic run_tx_frame();
    int   idx;
    int   n;
    logic done;
    logic clk_prev;
    tx_nibs.delete();
    repeat (rand_range(4, 16)) tx_nibs.push_back(nibble_t'(next_random() >> 12));
    model_tx_dibits();
    got_vals.delete();
    idx = 0;
    n = 0;
    done = 1'b0;
    clk_prev = mii_clk;
    while (!done && n < TX_TIMEOUT)
    begin
      next_cycle();
      n++;
      if (mii_clk != clk_prev)
      begin
        if (tx_en)
          got_vals.push_back({2'b00, txd});
        if (mii_clk && idx < tx_nibs.size())
        begin
          mii_tx_en = 1'b1;
          mii_txd   = tx_nibs[idx];
          idx++;
        end
        else if (mii_clk && mii_tx_en)
        begin
          mii_tx_en = 1'b0;
          mii_txd   = '0;
        end
        else if (mii_clk)
          done = !tx_en;
      end
      clk_prev = mii_clk;
    end
    if (!done)
      report_timeout("tx_en to return low");
    compare_stream("txd", 1'b0);
  endtask

  // Preamble, then the SFD dibit, then payload, then idle line
  task automatic drive_dibit(input int pos, input int k, input int err_idx);
    crs_dv = pos < k + 1 + data_dibits.size();
    rx_er  = (pos - k - 1) == err_idx;
    if (pos < k)
      rxd = PREAMBLE_DIBIT;
    else if (pos == k)
      rxd = SFD_DIBIT;
    else if (crs_dv)
      rxd = data_dibits[pos - k - 1];
    else
      rxd = '0;
  endtask

  task automatic run_rx_frame(input int hold);
    int   k;
    int   err_idx;
    int   pos;
    int   hold_cnt;
    int   quiet;
    int   n;
    logic clk_prev;
    logic saw_crs;
    k = rand_range(3, 15);
    data_dibits.delete();
    repeat (2 * rand_range(4, 12)) data_dibits.push_back(dibit_t'(next_random() >> 16));
    err_idx = rand_range(0, data_dibits.size() - 1);
    model_rx_nibbles(k, err_idx);
    got_vals.delete();
    got_errs.delete();
    wait_mii_clk(1'b1);   // Strobes run at the selected rate
    pos = 0;
    hold_cnt = 0;
    quiet = 0;
    n = 0;
    saw_crs = 1'b0;
    clk_prev = mii_clk;
    while (quiet < 3 && n < RX_TIMEOUT)
    begin
      next_cycle();
      n++;
      saw_crs |= crs;
      if (mii_clk && !clk_prev)
      begin
        if (rx_dv)
        begin
          got_vals.push_back(mii_rxd);
          got_errs.push_back(mii_rx_er);
        end
        quiet = (pos > k + 1 + data_dibits.size() && !rx_dv) ? quiet + 1 : 0;
      end
      clk_prev = mii_clk;
      if (hold_cnt > 0)
        hold_cnt--;
      else
      begin
        drive_dibit(pos, k, err_idx);
        pos++;
        hold_cnt = hold - 1;
      end
    end
    if (quiet < 3)
      report_timeout("the end of a receive frame");
    check_value("crs during frame", 1, saw_crs);
    check_value("crs after frame", 0, crs);
    compare_stream("mii_rxd", 1'b1);
  endtask

  task automatic test_false_carrier();
    int   n;
    logic saw_dv;
    apply_reset(1'b1);
    wait_mii_clk(1'b1);
    crs_dv = 1'b1;
    rxd    = 2'b10;   // Not a preamble code
    n = 0;
    saw_dv = 1'b0;
    while (!crs && n < EDGE_TIMEOUT)
    begin
      next_cycle();
      n++;
      saw_dv |= rx_dv;
    end
    if (!crs)
      report_timeout("crs on a false carrier");
    mii_tx_en = 1'b1;
    next_cycle();
    check_value("col", 1, col);
    mii_tx_en = 1'b0;
    next_cycle();
    check_value("col", 0, col);
    crs_dv = 1'b0;
    rxd    = '0;
    n = 0;
    while (crs && n < EDGE_TIMEOUT)
    begin
      next_cycle();
      n++;
      saw_dv |= rx_dv;
    end
    if (crs)
      report_timeout("crs to fall after a false carrier");
    // No collision without carrier
    mii_tx_en = 1'b1;
    next_cycle();
    check_value("col", 0, col);
    mii_tx_en = 1'b0;
    check_value("rx_dv", 0, saw_dv);
  endtask

  initial
  begin
    int errs0;
    RMRESETN  = 1'b0;
    speed     = 1'b1;
    crs_dv    = 1'b0;
    rx_er     = 1'b0;
    rxd       = '0;
    mii_tx_en = 1'b0;
    mii_txd   = '0;

    errs0 = error_count;
    apply_reset(1'b1);
    check_value("mii_clk", 0, mii_clk);
    check_value("tx_en", 0, tx_en);
    check_value("txd", 0, txd);
    check_value("rx_dv", 0, rx_dv);
    check_value("crs", 0, crs);
    check_value("mii_rx_er", 0, mii_rx_er);
    check_value("col", 0, col);
    measure_halves(1);
    apply_reset(1'b0);
    measure_halves(SLOW_DIV);
    end_test("reset and clock", errs0);

    errs0 = error_count;
    apply_reset(1'b1);
    repeat (3) run_tx_frame();
    end_test("transmit at 100 Mb/s", errs0);

    errs0 = error_count;
    repeat (3) run_rx_frame(1);
    end_test("receive at 100 Mb/s", errs0);

    errs0 = error_count;
    apply_reset(1'b0);
    repeat (2) run_tx_frame();
    repeat (2) run_rx_frame(SLOW_DIV);
    end_test("transmit and receive at 10 Mb/s", errs0);

    errs0 = error_count;
    test_false_carrier();
    end_test("false carrier and collision", errs0);

    $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+tests
source/rmii_pkg.sv
source/mii_clock_gen.sv
source/rmii_tx_serializer.sv
source/rmii_rx_framer.sv
source/rx_nibble_buffer.sv
source/rmii_mii_bridge.sv
tests/tb_rmii_mii.sv

// File: run_sim.sh
#!/bin/sh
# Build the RMII to MII bridge testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_rmii_mii -Mdir obj_dir -o tb_sim; then
  echo "Verilator compile failed"
  exit 1
fi

if ! ./obj_dir/tb_sim > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation exited with an error status"
  exit 1
fi

cat "$LOG"

if grep -q "Test failed" "$LOG"; then
  exit 1
fi

exit 0
